/* src/mac_defines.svh */
`ifndef MAC_DEFINES_SVH
`define MAC_DEFINES_SVH

// ==========================================================================
// datapath widths
// ==========================================================================

`define MAC_OP_W        16      // signed a and b operands.
`define MAC_ACC_W       32      // accumulator, wraps mod 2^32.
`define MAC_CNT_W       16      // step counter in status.

// ==========================================================================
// axi4-lite bus and register map
// ==========================================================================

`define MAC_AXI_AW      4
`define MAC_AXI_DW      32

`define MAC_REG_OPERAND 4'h0    // write {b, a}, issues one step.
`define MAC_REG_CTRL    4'h4    // bit 0 clears accumulator.
`define MAC_REG_RESULT  4'h8
`define MAC_REG_STATUS  4'hC

`endif

/* src/mac_pkg.sv */
`include "mac_defines.svh"

package mac_pkg;

    // b sits in the upper half of the write word.
    typedef struct packed {
        logic signed [`MAC_OP_W-1:0] b;
        logic signed [`MAC_OP_W-1:0] a;
    } mac_operands_t;

    typedef struct packed {
        logic [`MAC_AXI_DW-2:0] rsvd;
        logic                   clear;
    } mac_ctrl_t;

    // same write word, seen as operands or as control depending on offset.
    typedef union packed {
        mac_operands_t ops;
        mac_ctrl_t     ctrl;
    } mac_wdata_u;

    // one multiply-accumulate request.
    typedef struct packed {
        logic          issue;
        mac_operands_t ops;
    } mac_step_t;

    typedef struct packed {
        logic [`MAC_CNT_W-1:0]              count;  // steps since last clear.
        logic [`MAC_AXI_DW-`MAC_CNT_W-2:0]  rsvd;
        logic                               busy;
    } mac_status_t;

endpackage

/* src/mac16_accum.sv */
`timescale 1ns/1ps

`include "mac_defines.svh"

module mac16_accum (
    input  logic                          i_clk,
    input  logic                          i_arst_n,
    input  logic                          i_clear,
    input  mac_pkg::mac_step_t            i_step,
    output logic signed [`MAC_ACC_W-1:0]  o_result,
    output logic                          o_busy
);

    // ======================================================================
    // stage one, operand registers
    // ======================================================================

    logic signed [`MAC_OP_W-1:0]  a_q;
    logic signed [`MAC_OP_W-1:0]  b_q;
    logic                         s1_vld_q;

    // loaded only on issue, so a held pair never re-enters the sum.
    always_ff @(posedge i_clk) begin
        if (i_step.issue) begin
            a_q <= i_step.ops.a;
            b_q <= i_step.ops.b;
        end
    end

    // ======================================================================
    // stage two, multiply and accumulate
    // ======================================================================

    logic signed [`MAC_ACC_W-1:0] product;
    logic signed [`MAC_ACC_W-1:0] acc_q;
    logic                         s2_vld_q;

    // 16x16 signed fits exactly in 32 bits.
    assign product = a_q * b_q;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            s1_vld_q <= 1'b0;
            s2_vld_q <= 1'b0;
            acc_q    <= '0;
        end else if (i_clear) begin
            // issue in the same cycle is dropped.
            s1_vld_q <= 1'b0;
            s2_vld_q <= 1'b0;
            acc_q    <= '0;
        end else begin
            s1_vld_q <= i_step.issue;
            s2_vld_q <= s1_vld_q;
            if (s1_vld_q) begin
                acc_q <= acc_q + product;   // wraps like the primitive.
            end
        end
    end

    // ======================================================================
    // outputs
    // ======================================================================

    assign o_result = acc_q;

    // s2 marks the cycle right after an update.
    assign o_busy = s1_vld_q | s2_vld_q;

endmodule

/* src/axil_mac_regs.sv */
`timescale 1ns/1ps

`include "mac_defines.svh"

module axil_mac_regs (
    input  logic                          i_clk,
    input  logic                          i_arst_n,

    // write address and data.
    input  logic                          i_awvalid,
    input  logic [`MAC_AXI_AW-1:0]        i_awaddr,
    output logic                          o_awready,
    input  logic                          i_wvalid,
    input  logic [`MAC_AXI_DW-1:0]        i_wdata,
    output logic                          o_wready,

    // write response.
    output logic                          o_bvalid,
    output logic [1:0]                    o_bresp,
    input  logic                          i_bready,

    // read address and data.
    input  logic                          i_arvalid,
    input  logic [`MAC_AXI_AW-1:0]        i_araddr,
    output logic                          o_arready,
    output logic                          o_rvalid,
    output logic [`MAC_AXI_DW-1:0]        o_rdata,
    output logic [1:0]                    o_rresp,
    input  logic                          i_rready,

    // accumulator side.
    output mac_pkg::mac_step_t            o_step,
    output logic                          o_clear,
    input  logic signed [`MAC_ACC_W-1:0]  i_result,
    input  logic                          i_busy
);

    import mac_pkg::*;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    mac_wdata_u              wdata;
    mac_status_t             status;

    logic                    aw_rdy_q;
    logic                    bvalid_q;
    logic                    wr_en;
    logic                    wr_op;
    logic                    wr_ctrl;
    logic                    step_issue;
    logic                    clear_pulse;

    logic                    ar_rdy_q;
    logic                    rvalid_q;
    logic                    rd_en;
    logic                    rd_result;
    logic                    rd_ok;
    logic [`MAC_AXI_DW-1:0]  rd_word;
    logic [`MAC_AXI_DW-1:0]  rdata_q;

    logic [`MAC_CNT_W-1:0]   cnt_q;

    // ======================================================================
    // write channel
    // ======================================================================

    // aw and w are taken together, one write in flight at a time.
    assign wr_en = aw_rdy_q & i_awvalid & i_wvalid;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            aw_rdy_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            aw_rdy_q <= ~aw_rdy_q & i_awvalid & i_wvalid & ~bvalid_q;
            if (wr_en) begin
                bvalid_q <= 1'b1;
            end else if (i_bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    assign o_awready = aw_rdy_q;
    assign o_wready  = aw_rdy_q;
    assign o_bvalid  = bvalid_q;
    assign o_bresp   = RESP_OKAY;

    // ======================================================================
    // write decode
    // ======================================================================

    assign wdata   = i_wdata;
    assign wr_op   = (i_awaddr == `MAC_REG_OPERAND);
    assign wr_ctrl = (i_awaddr == `MAC_REG_CTRL);

    // unmapped offsets are dropped here.
    assign step_issue  = wr_en & wr_op;
    assign clear_pulse = wr_en & wr_ctrl & wdata.ctrl.clear;

    assign o_step  = '{issue: step_issue, ops: wdata.ops};
    assign o_clear = clear_pulse;

    // step count, wraps.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt_q <= '0;
        end else if (clear_pulse) begin
            cnt_q <= '0;
        end else if (step_issue) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign status = '{count: cnt_q, rsvd: '0, busy: i_busy};

    // ======================================================================
    // read channel
    // ======================================================================

    assign rd_result = (i_araddr == `MAC_REG_RESULT);

    // result waits for an empty pipeline, and for a step issued right now.
    assign rd_ok = ~rd_result | (~i_busy & ~step_issue);
    assign rd_en = ar_rdy_q & i_arvalid;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ar_rdy_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            ar_rdy_q <= ~ar_rdy_q & i_arvalid & ~rvalid_q & rd_ok;
            if (rd_en) begin
                rvalid_q <= 1'b1;
            end else if (i_rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_comb begin
        case (i_araddr)
            `MAC_REG_RESULT: rd_word = i_result;
            `MAC_REG_STATUS: rd_word = status;
            default:         rd_word = '0;  // operand and ctrl are write-only.
        endcase
    end

    // held until rready.
    always_ff @(posedge i_clk) begin
        if (rd_en) begin
            rdata_q <= rd_word;
        end
    end

    assign o_arready = ar_rdy_q;
    assign o_rvalid  = rvalid_q;
    assign o_rdata   = rdata_q;
    assign o_rresp   = RESP_OKAY;

endmodule

/* src/mac_unit_top.sv */
`timescale 1ns/1ps

`include "mac_defines.svh"

module mac_unit_top (
    input  logic                    i_clk,
    input  logic                    i_arst_n,

    input  logic                    i_awvalid,
    input  logic [`MAC_AXI_AW-1:0]  i_awaddr,
    output logic                    o_awready,
    input  logic                    i_wvalid,
    input  logic [`MAC_AXI_DW-1:0]  i_wdata,
    output logic                    o_wready,
    output logic                    o_bvalid,
    output logic [1:0]              o_bresp,
    input  logic                    i_bready,

    input  logic                    i_arvalid,
    input  logic [`MAC_AXI_AW-1:0]  i_araddr,
    output logic                    o_arready,
    output logic                    o_rvalid,
    output logic [`MAC_AXI_DW-1:0]  o_rdata,
    output logic [1:0]              o_rresp,
    input  logic                    i_rready
);

    import mac_pkg::*;

    mac_step_t                    step;
    logic                         clear;
    logic signed [`MAC_ACC_W-1:0] result;
    logic                         busy;

    // ======================================================================
    // register block
    // ======================================================================

    axil_mac_regs u_regs (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_awvalid (i_awvalid),
        .i_awaddr  (i_awaddr),
        .o_awready (o_awready),
        .i_wvalid  (i_wvalid),
        .i_wdata   (i_wdata),
        .o_wready  (o_wready),
        .o_bvalid  (o_bvalid),
        .o_bresp   (o_bresp),
        .i_bready  (i_bready),
        .i_arvalid (i_arvalid),
        .i_araddr  (i_araddr),
        .o_arready (o_arready),
        .o_rvalid  (o_rvalid),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp),
        .i_rready  (i_rready),
        .o_step    (step),
        .o_clear   (clear),
        .i_result  (result),
        .i_busy    (busy)
    );

    // ======================================================================
    // accumulator, in place of the dsp block
    // ======================================================================

    mac16_accum u_mac (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_clear  (clear),
        .i_step   (step),
        .o_result (result),
        .o_busy   (busy)
    );

endmodule

/* test/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 10.0,
    parameter int  RST_CYCLES = 4
) (
    output logic o_clk,
    output logic o_arst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

    // reset falls just after time zero so every flop sees the edge.
    initial begin
        o_arst_n = 1'b1;
        #1;
        o_arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_arst_n = 1'b1;    // released away from the sampling edge.
    end

endmodule

/* test/mac_unit_checker.sv */
`timescale 1ns/1ps

`include "mac_defines.svh"

module mac_unit_checker (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_awvalid,
    input  logic                    i_awready,
    input  logic [`MAC_AXI_AW-1:0]  i_awaddr,
    input  logic                    i_wvalid,
    input  logic                    i_wready,
    input  logic [`MAC_AXI_DW-1:0]  i_wdata,
    input  logic                    i_bvalid,
    input  logic                    i_bready,
    input  logic [1:0]              i_bresp,
    input  logic                    i_arvalid,
    input  logic                    i_arready,
    input  logic [`MAC_AXI_AW-1:0]  i_araddr,
    input  logic                    i_rvalid,
    input  logic                    i_rready,
    input  logic [`MAC_AXI_DW-1:0]  i_rdata,
    input  logic [1:0]              i_rresp,
    input  logic                    i_issue,
    input  logic                    i_clear
);

    import mac_pkg::*;

    int                           chk_fails = 0;
    mac_wdata_u                   wword;
    logic signed [`MAC_ACC_W-1:0] acc_model;
    logic signed [`MAC_ACC_W-1:0] rd_exp;
    logic                         rd_is_result;

    assign wword = i_wdata;

    // ======================================================================
    // reference accumulator, built from port handshakes
    // ======================================================================

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            acc_model <= '0;
        end else if (i_awvalid & i_awready & i_wvalid & i_wready) begin
            if (i_awaddr == `MAC_REG_OPERAND) begin
                acc_model <= acc_model + wword.ops.a * wword.ops.b;  // wraps mod 2^32.
            end else if (i_awaddr == `MAC_REG_CTRL && wword.ctrl.clear) begin
                acc_model <= '0;
            end
        end
    end

    // value due on the r channel, latched at the ar handshake.
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_is_result <= 1'b0;
            rd_exp       <= '0;
        end else if (i_arvalid & i_arready) begin
            rd_is_result <= (i_araddr == `MAC_REG_RESULT);
            rd_exp       <= acc_model;
        end
    end

    // ======================================================================
    // assertions
    // ======================================================================

    b_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
        else begin
            $error("write response dropped or changed while bready was low");
            chk_fails++;
        end

    r_held: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp))
        else begin
            $error("read response dropped or changed while rready was low");
            chk_fails++;
        end

    result_ok: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        rd_is_result && i_rvalid |-> i_rdata == rd_exp)
        else begin
            $error("result read %08h, reference holds %08h", i_rdata, rd_exp);
            chk_fails++;
        end

    quiet_in_reset: assert property (@(posedge i_clk)
        !i_arst_n |-> !(i_awready | i_wready | i_arready | i_bvalid | i_rvalid
                        | i_issue | i_clear))
        else begin
            $error("control output high during reset");
            chk_fails++;
        end

endmodule

/* test/mac_unit_tb.sv */
`timescale 1ns/1ps

`include "mac_defines.svh"

module mac_unit_tb;

    import mac_pkg::*;

    // 50 bus transactions in all tests together.
    localparam int N_XACT      = 50;
    localparam int CYCLE_LIMIT = 40 * N_XACT + 200;

    logic                   clk;
    logic                   arst_n;
    logic                   awvalid, awready, wvalid, wready;
    logic [`MAC_AXI_AW-1:0] awaddr;
    logic [`MAC_AXI_DW-1:0] wdata;
    logic                   bvalid, bready;
    logic [1:0]             bresp;
    logic                   arvalid, arready, rvalid, rready;
    logic [`MAC_AXI_AW-1:0] araddr;
    logic [`MAC_AXI_DW-1:0] rdata;
    logic [1:0]             rresp;

    logic signed [`MAC_ACC_W-1:0] exp_acc;
    logic [`MAC_CNT_W-1:0]        exp_cnt;

    int seed = 17;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int test_no = 1;
    int errs_at_start = 0;

    tb_clk_gen #(.PERIOD_NS(10.0), .RST_CYCLES(4)) u_clk (
        .o_clk    (clk),
        .o_arst_n (arst_n)
    );

    mac_unit_top u_dut (
        .i_clk     (clk),
        .i_arst_n  (arst_n),
        .i_awvalid (awvalid),
        .i_awaddr  (awaddr),
        .o_awready (awready),
        .i_wvalid  (wvalid),
        .i_wdata   (wdata),
        .o_wready  (wready),
        .o_bvalid  (bvalid),
        .o_bresp   (bresp),
        .i_bready  (bready),
        .i_arvalid (arvalid),
        .i_araddr  (araddr),
        .o_arready (arready),
        .o_rvalid  (rvalid),
        .o_rdata   (rdata),
        .o_rresp   (rresp),
        .i_rready  (rready)
    );

    function automatic int total_errors();
        return errors + u_dut.u_checker.chk_fails;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
            else begin
                $display("MISMATCH at %0t: %s read %08h, expected %08h",
                         $time, what, got, exp);
                errors++;
            end
    endtask

    // ======================================================================
    // axi4-lite bus tasks, called on a falling edge
    // ======================================================================

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input int hold);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        @(negedge clk);
        while (!awready) @(negedge clk);
        if (!wready) begin
            $display("wready low at %0t while awready was high", $time);
            errors++;
        end
        @(negedge clk);     // handshake done.
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat (hold) begin
            if (!bvalid) begin
                $display("write response vanished at %0t while bready was low", $time);
                errors++;
            end
            @(negedge clk);
        end
        bready = 1'b1;
        while (!bvalid) @(negedge clk);
        check_value("bresp", 32'(bresp), 32'h0);
        @(negedge clk);
    endtask

    task automatic axi_read(input logic [3:0] addr, input int hold,
                            output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        @(negedge clk);
        while (!arready) @(negedge clk);    // result reads wait out busy.
        @(negedge clk);
        arvalid = 1'b0;
        data    = rdata;
        repeat (hold) begin
            if (!rvalid || rdata !== data) begin
                $display("read response not held at %0t while rready was low", $time);
                errors++;
            end
            @(negedge clk);
        end
        rready = 1'b1;
        while (!rvalid) @(negedge clk);
        data = rdata;
        check_value("rresp", 32'(rresp), 32'h0);
        @(negedge clk);
    endtask

    task automatic push_operands(input logic signed [15:0] a, input logic signed [15:0] b,
                                 input int hold);
        mac_operands_t ops;
        ops.a = a;
        ops.b = b;
        axi_write(`MAC_REG_OPERAND, ops, hold);
        exp_acc = exp_acc + a * b;
        exp_cnt = exp_cnt + 1'b1;
    endtask

    task automatic write_ctrl(input logic [31:0] data);
        mac_ctrl_t ctrl;
        ctrl = data;
        axi_write(`MAC_REG_CTRL, data, 0);
        if (ctrl.clear) begin
            exp_acc = '0;
            exp_cnt = '0;
        end
    endtask

    task automatic check_result(input int hold);
        logic [31:0] d;
        axi_read(`MAC_REG_RESULT, hold, d);
        check_value("result", d, exp_acc);
    endtask

    task automatic check_status(input int hold);
        logic [31:0] d;
        mac_status_t st;
        st.count = exp_cnt;
        st.rsvd  = '0;
        st.busy  = 1'b0;    // reads come after the pipeline drains.
        axi_read(`MAC_REG_STATUS, hold, d);
        check_value("status", d, st);
    endtask

    task automatic finish_test(input string name);
        $display("test %0d %s %s", test_no, name,
                 (total_errors() == errs_at_start) ? "ok" : "FAILED");
        test_no++;
        errs_at_start = total_errors();
    endtask

    // ======================================================================
    // tests
    // ======================================================================

    initial begin
        logic [31:0] rnd;
        logic [31:0] d;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        exp_acc = '0;
        exp_cnt = '0;

        wait (arst_n === 1'b0);
        wait (arst_n === 1'b1);
        @(negedge clk);

        check_result(0);
        check_status(0);
        finish_test("reset values");

        for (int i = 0; i < 20; i++) begin
            rnd = $random(seed);
            case (i)
                0:       push_operands(-16'sd32768, -16'sd32768, 0);
                7:       push_operands(-16'sd32768, 16'sd32767, 0);
                13:      push_operands(16'sd32767, -16'sd32768, 0);
                default: push_operands(rnd[15:0], rnd[31:16], 0);
            endcase
        end
        check_result(0);
        check_status(0);
        finish_test("random accumulate");

        for (int i = 0; i < 7; i++) begin
            rnd = $random(seed);
            push_operands(rnd[15:0], rnd[31:16], 0);
        end
        // read address arrives while the last step is still being issued.
        rnd = $random(seed);
        fork
            push_operands(rnd[15:0], rnd[31:16], 0);
            begin
                @(negedge clk);
                check_result(0);
            end
        join
        finish_test("back-to-back");

        write_ctrl(32'h0000_0001);
        check_result(0);
        check_status(0);
        push_operands(16'sd1234, -16'sd567, 0);
        push_operands(-16'sd300, -16'sd300, 0);
        write_ctrl(32'hFFFF_FFFE);  // clear bit low.
        check_result(0);
        check_status(0);
        finish_test("clear");

        for (int i = 0; i < 3; i++) begin
            rnd = $random(seed);
            push_operands(rnd[15:0], rnd[31:16], 5);
        end
        check_result(6);
        check_status(4);
        finish_test("back-pressure");

        axi_write(4'h3, 32'h0001_0001, 0);
        check_result(0);
        check_status(0);
        axi_read(4'h6, 0, d);
        check_value("unmapped", d, 32'h0);
        finish_test("unmapped offsets");

        $display("%0d tests, %0d checks, %0d errors", test_no - 1, checks, total_errors());
        if (total_errors() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // run limit.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a bus handshake never completed", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

bind mac_unit_top mac_unit_checker u_checker (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_awvalid (i_awvalid),
    .i_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .i_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .i_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .i_arready (o_arready),
    .i_araddr  (i_araddr),
    .i_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .i_rdata   (o_rdata),
    .i_rresp   (o_rresp),
    .i_issue   (step.issue),
    .i_clear   (clear)
);

/* sim.f */
+incdir+src
src/mac_pkg.sv
src/mac16_accum.sv
src/axil_mac_regs.sv
src/mac_unit_top.sv
test/tb_clk_gen.sv
test/mac_unit_checker.sv
test/mac_unit_tb.sv
